// File: hw/rv_core_settings.svh
// Width and reset settings shared by the RV64 pipeline blocks
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// Datapath
`define RV_XLEN     64
`define RV_ILEN     32      // Instruction word

// Register file
`define RV_NREG     32
`define RV_REG_W    5

// Byte addresses on the instruction and data ports
`define RV_PC_W     32

// First fetch after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// File: hw/rv_isa_pkg.sv
// RV64 instruction set encodings for the kept integer subset
package rv_isa_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } rv_opcode_e;

    // Operations the execute ALU understands
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_SLL = 4'd2,
        ALU_SLT = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SRL = 4'd5,
        ALU_SRA = 4'd6,
        ALU_OR  = 4'd7,
        ALU_AND = 4'd8
    } alu_op_e;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;   // Not supported
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // SRL/SRA, picked by instr[30]
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for branches and memory ops
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_LD   = 3'b011;
    localparam logic [2:0] F3_SD   = 3'b011;

endpackage

// File: hw/rv_pipe_pkg.sv
// Pipeline register, writeback, redirect and data memory types
`include "rv_core_settings.svh"

package rv_pipe_pkg;
    import rv_isa_pkg::*;

    // Sequential fetch step in bytes
    localparam logic [`RV_PC_W-1:0] PC_STEP = 4;

    // Decoded control bits
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;    // Load
        logic    mem_write;     // Store
        logic    alu_src_imm;
        logic    branch;
        logic    jal;
        alu_op_e alu_op;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        logic                 valid;
        ctrl_t                ctrl;
        logic [`RV_PC_W-1:0]  pc;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        logic [2:0]           funct3;
        logic [`RV_XLEN-1:0]  imm;
        logic [`RV_XLEN-1:0]  rdata1;
        logic [`RV_XLEN-1:0]  rdata2;
    } id_ex_t;

    // Execute to memory
    typedef struct packed {
        logic                 valid;
        logic                 reg_write;
        logic                 mem_to_reg;
        logic                 mem_write;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  result;      // ALU value or JAL link
        logic [`RV_XLEN-1:0]  store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                 wen;
        logic [`RV_REG_W-1:0] rd;
        logic [`RV_XLEN-1:0]  data;
    } wb_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_PC_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic                wen;
        logic [`RV_PC_W-1:0] address;
        logic [`RV_XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

// File: hw/rv_regfile.sv
// Integer register file, 32 x 64 bit, x0 tied to zero, write-first reads
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`RV_REG_W-1:0] rs1_i,
    input  logic [`RV_REG_W-1:0] rs2_i,
    input  logic                 wen_i,
    input  logic [`RV_REG_W-1:0] rd_i,
    input  logic [`RV_XLEN-1:0]  wdata_i,
    output logic [`RV_XLEN-1:0]  rdata1_o,
    output logic [`RV_XLEN-1:0]  rdata2_o
);

    logic [`RV_XLEN-1:0] regs [`RV_NREG];
    logic                wr_live;

    assign wr_live = wen_i && (rd_i != '0);    // x0 writes dropped

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[rd_i] <= wdata_i;
        end
    end

    // Same-cycle write wins over the stored value
    assign rdata1_o = (wr_live && rd_i == rs1_i) ? wdata_i : regs[rs1_i];
    assign rdata2_o = (wr_live && rd_i == rs2_i) ? wdata_i : regs[rs2_i];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (rs1_i == '0 |-> rdata1_o == '0) and (rs2_i == '0 |-> rdata2_o == '0));

endmodule

// File: hw/rv_fetch_decode.sv
// Fetch and decode, PC, immediates, load-use stall and the decode/execute register
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_fetch_decode
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    output logic [`RV_PC_W-1:0] imem_addr_o,
    input  logic [`RV_ILEN-1:0] imem_rdata_i,
    input  redirect_t           redirect_i,
    input  wb_t                 wb_i,
    output id_ex_t              id_ex_o
);

    localparam int XLEN = `RV_XLEN;

    logic [`RV_PC_W-1:0]  pc;
    logic                 fd_valid;     // Fetch/decode register
    logic [`RV_PC_W-1:0]  fd_pc;
    logic [`RV_ILEN-1:0]  fd_instr;

    rv_opcode_e           opcode;
    logic [2:0]           funct3;
    logic [`RV_REG_W-1:0] rs1;
    logic [`RV_REG_W-1:0] rs2;
    logic [`RV_REG_W-1:0] rd;
    logic [XLEN-1:0]      i_imm;
    logic [XLEN-1:0]      s_imm;
    logic [XLEN-1:0]      b_imm;
    logic [XLEN-1:0]      j_imm;
    logic [XLEN-1:0]      rdata1;
    logic [XLEN-1:0]      rdata2;
    ctrl_t                ctrl;
    logic [XLEN-1:0]      imm;
    logic                 legal;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 stall;
    id_ex_t               id_ex_d;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic is_op);
        alu_op_e op;
        case (f3)
            F3_ADD:  op = (alt && is_op) ? ALU_SUB : ALU_ADD;   // No SUBI
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    assign imem_addr_o = pc;

    assign opcode = rv_opcode_e'(fd_instr[6:0]);
    assign funct3 = fd_instr[14:12];
    assign rs1    = fd_instr[19:15];
    assign rs2    = fd_instr[24:20];
    assign rd     = fd_instr[11:7];

    // Sign-extended immediates
    assign i_imm = {{(XLEN-12){fd_instr[31]}}, fd_instr[31:20]};
    assign s_imm = {{(XLEN-12){fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
    assign b_imm = {{(XLEN-12){fd_instr[31]}}, fd_instr[7], fd_instr[30:25],
                    fd_instr[11:8], 1'b0};
    assign j_imm = {{(XLEN-20){fd_instr[31]}}, fd_instr[19:12], fd_instr[20],
                    fd_instr[30:21], 1'b0};

    rv_regfile i_regfile (
        .clk      (clk),
        .rst      (rst),
        .rs1_i    (rs1),
        .rs2_i    (rs2),
        .wen_i    (wb_i.wen),
        .rd_i     (wb_i.rd),
        .wdata_i  (wb_i.data),
        .rdata1_o (rdata1),
        .rdata2_o (rdata2)
    );

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;      // Address and link adds
        imm         = i_imm;
        legal       = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b0;
        case (opcode)
            OPC_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                legal            = (funct3 == F3_LD);
            end
            OPC_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = s_imm;
                use_rs2          = 1'b1;
                legal            = (funct3 == F3_SD);
            end
            OPC_OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = alu_decode(funct3, fd_instr[30], 1'b0);
                legal            = (funct3 != F3_SLTU);
            end
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, fd_instr[30], 1'b1);
                use_rs2        = 1'b1;
                legal          = (funct3 != F3_SLTU);
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                imm         = b_imm;
                use_rs2     = 1'b1;
                legal       = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = 1'b1;
                imm            = j_imm;
                use_rs1        = 1'b0;
            end
            default: legal = 1'b0;      // Unknown opcode, send a bubble
        endcase
    end

    // Load in execute feeding the instruction in decode
    assign stall = fd_valid && id_ex_o.valid && id_ex_o.ctrl.mem_to_reg &&
                   (id_ex_o.rd != '0) &&
                   ((use_rs1 && id_ex_o.rd == rs1) || (use_rs2 && id_ex_o.rd == rs2));

    always_comb begin
        id_ex_d        = '0;
        id_ex_d.valid  = fd_valid && legal;
        id_ex_d.ctrl   = ctrl;
        id_ex_d.pc     = fd_pc;
        id_ex_d.rs1    = rs1;
        id_ex_d.rs2    = rs2;
        id_ex_d.rd     = rd;
        id_ex_d.funct3 = funct3;
        id_ex_d.imm    = imm;
        id_ex_d.rdata1 = rdata1;
        id_ex_d.rdata2 = rdata2;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc       <= `RV_RESET_PC;
            fd_valid <= 1'b0;
            fd_pc    <= '0;
            fd_instr <= '0;
            id_ex_o  <= '0;
        end else if (redirect_i.valid) begin
            pc            <= redirect_i.target;
            fd_valid      <= 1'b0;        // Kill both younger instructions
            id_ex_o.valid <= 1'b0;
        end else if (stall) begin
            id_ex_o.valid <= 1'b0;        // PC and fetch/decode hold
        end else begin
            pc       <= pc + PC_STEP;
            fd_valid <= 1'b1;
            fd_pc    <= pc;
            fd_instr <= imem_rdata_i;
            id_ex_o  <= id_ex_d;
        end
    end

    // A load in execute never resolves as a taken branch or jump
    a_stall_redirect: assert property (@(posedge clk) disable iff (rst)
        !(stall && redirect_i.valid));

endmodule

// File: hw/rv_execute.sv
// Execute stage, operand forwarding, ALU, branch/JAL resolution, execute/memory register
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_execute
    import rv_isa_pkg::*, rv_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  id_ex_t    id_ex_i,
    input  wb_t       wb_i,
    output redirect_t redirect_o,
    output ex_mem_t   ex_mem_o
);

    localparam int XLEN = `RV_XLEN;

    logic            mem_hit1;
    logic            mem_hit2;
    logic            wb_hit1;
    logic            wb_hit2;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b_reg;      // rs2 after forwarding, also store data
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] link;
    logic            equal;
    logic            taken;

    // Memory stage wins, loads there are not ready yet
    assign mem_hit1 = ex_mem_o.valid && ex_mem_o.reg_write && !ex_mem_o.mem_to_reg &&
                      (ex_mem_o.rd != '0) && (ex_mem_o.rd == id_ex_i.rs1);
    assign mem_hit2 = ex_mem_o.valid && ex_mem_o.reg_write && !ex_mem_o.mem_to_reg &&
                      (ex_mem_o.rd != '0) && (ex_mem_o.rd == id_ex_i.rs2);
    assign wb_hit1  = wb_i.wen && (wb_i.rd != '0) && (wb_i.rd == id_ex_i.rs1);
    assign wb_hit2  = wb_i.wen && (wb_i.rd != '0) && (wb_i.rd == id_ex_i.rs2);

    assign op_a     = mem_hit1 ? ex_mem_o.result :
                      wb_hit1  ? wb_i.data       : id_ex_i.rdata1;
    assign op_b_reg = mem_hit2 ? ex_mem_o.result :
                      wb_hit2  ? wb_i.data       : id_ex_i.rdata2;
    assign op_b     = id_ex_i.ctrl.alu_src_imm ? id_ex_i.imm : op_b_reg;
    assign shamt    = op_b[5:0];    // RV64 shift amount

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_ADD: alu_res = op_a + op_b;
            ALU_SUB: alu_res = op_a - op_b;
            ALU_SLL: alu_res = op_a << shamt;
            ALU_SLT: alu_res = XLEN'($signed(op_a) < $signed(op_b));
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SRL: alu_res = op_a >> shamt;
            ALU_SRA: alu_res = $signed(op_a) >>> shamt;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_AND: alu_res = op_a & op_b;
            default: alu_res = op_a + op_b;
        endcase
    end

    assign link  = XLEN'(id_ex_i.pc + PC_STEP);
    assign equal = (op_a == op_b_reg);

    // BNE inverts the equality test
    assign taken = id_ex_i.valid &&
                   ((id_ex_i.ctrl.branch && (equal ^ (id_ex_i.funct3 == F3_BNE))) ||
                    id_ex_i.ctrl.jal);

    assign redirect_o.valid  = taken;
    assign redirect_o.target = id_ex_i.pc + id_ex_i.imm[`RV_PC_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o.valid      <= id_ex_i.valid;
            ex_mem_o.reg_write  <= id_ex_i.ctrl.reg_write;
            ex_mem_o.mem_to_reg <= id_ex_i.ctrl.mem_to_reg;
            ex_mem_o.mem_write  <= id_ex_i.ctrl.mem_write;
            ex_mem_o.rd         <= id_ex_i.rd;
            ex_mem_o.result     <= id_ex_i.ctrl.jal ? link : alu_res;
            ex_mem_o.store_data <= op_b_reg;
        end
    end

    // Only control flow redirects, and the next slot in execute is a bubble
    a_redirect_src: assert property (@(posedge clk) disable iff (rst)
        redirect_o.valid |-> (id_ex_i.ctrl.branch || id_ex_i.ctrl.jal) ##1 !id_ex_i.valid);

endmodule

// File: hw/rv_mem_wb.sv
// Memory access and writeback, data memory request and memory/writeback register
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_mem_wb
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  ex_mem_t             ex_mem_i,
    output dmem_req_t           dmem_req_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i,
    output wb_t                 wb_o
);

    logic [`RV_XLEN-1:0] wb_data;

    // Address comes from the ALU sum, memory answers in the same cycle
    assign dmem_req_o.wen     = ex_mem_i.valid && ex_mem_i.mem_write;
    assign dmem_req_o.address = ex_mem_i.result[`RV_PC_W-1:0];
    assign dmem_req_o.wdata   = ex_mem_i.store_data;

    assign wb_data = ex_mem_i.mem_to_reg ? dmem_rdata_i : ex_mem_i.result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_o <= '0;
        end else begin
            wb_o.wen  <= ex_mem_i.valid && ex_mem_i.reg_write;
            wb_o.rd   <= ex_mem_i.rd;
            wb_o.data <= wb_data;
        end
    end

    // A store is never a load and never reaches the register file
    a_store_only: assert property (@(posedge clk) disable iff (rst)
        dmem_req_o.wen |-> !ex_mem_i.mem_to_reg ##1 !wb_o.wen);

endmodule

// File: hw/rv_core.sv
// RV64 five-stage in-order core, joins fetch/decode, execute and memory/writeback
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_core
    import rv_pipe_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    // Instruction memory
    output logic [`RV_PC_W-1:0] imem_addr_o,
    input  logic [`RV_ILEN-1:0] imem_rdata_i,
    // Data memory
    output dmem_req_t           dmem_req_o,
    input  logic [`RV_XLEN-1:0] dmem_rdata_i
);

    id_ex_t    id_ex;
    redirect_t redirect;      // Combinational from execute
    ex_mem_t   ex_mem;
    wb_t       wb;            // Register write and last forwarding source

    rv_fetch_decode i_fetch_decode (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .redirect_i   (redirect),
        .wb_i         (wb),
        .id_ex_o      (id_ex)
    );

    rv_execute i_execute (
        .clk        (clk),
        .rst        (rst),
        .id_ex_i    (id_ex),
        .wb_i       (wb),
        .redirect_o (redirect),
        .ex_mem_o   (ex_mem)
    );

    rv_mem_wb i_mem_wb (
        .clk          (clk),
        .rst          (rst),
        .ex_mem_i     (ex_mem),
        .dmem_req_o   (dmem_req_o),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_o         (wb)
    );

endmodule

// File: test/rv_core_tests.svh
// Directed tests for the RV64 core, each builds a program, runs it and checks data memory

// Reset values and the cycle in which the first store reaches memory
task automatic reset_state();
    int cyc;
    begin_program();
    emit(i_type(12'h005, 0, F3_ADD, 1, OPC_OP_IMM));
    emit(i_type(12'h003, 1, F3_ADD, 2, OPC_OP_IMM));
    emit(store_dword(2, 12'h000));      // Fetched in cycle 2, memory stage in cycle 5
    close_program();
    check_value("reset_state pc", 64'd0, 64'(imem_addr));
    check_value("reset_state wen", 64'd0, 64'(dmem_req.wen));
    cyc = 0;
    while (!dmem_req.wen && cyc < DONE_TIMEOUT) begin
        @(posedge clk);
        #DRIVE_DLY;
        cyc++;
    end
    check_value("reset_state first store cycle", 64'd5, 64'(cyc));
    wait_done("reset_state");
    check_word("reset_state", 32'h0, 64'd8);
endtask

// One link of the chain, the operation on x3 and a store of x3 to its own slot
task automatic chain_step(input logic [31:0] instr, input logic [63:0] result);
    emit(instr);
    emit(store_dword(3, 12'(16 + 8 * chain_want.size())));
    chain_want.push_back(result);
    chain = result;
endtask

task automatic alu_chain();
    logic [63:0] b;
    begin_program();
    chain = dmem[0];
    b = dmem[1];
    chain_want.delete();
    emit(load_dword(3, 12'h000));
    emit(load_dword(2, 12'h008));
    chain_step(r_type(7'h00, 2, 3, F3_ADD, 3), chain + b);
    chain_step(r_type(7'h20, 2, 3, F3_ADD, 3), chain - b);
    chain_step(r_type(7'h00, 2, 3, F3_XOR, 3), chain ^ b);
    chain_step(r_type(7'h00, 2, 3, F3_SLL, 3), chain << b[5:0]);
    chain_step(i_type(12'h7A5, 3, F3_ADD, 3, OPC_OP_IMM), chain + sx12(12'h7A5));
    chain_step(r_type(7'h00, 2, 3, F3_SR, 3), chain >> b[5:0]);
    chain_step(i_type(12'hF0F, 3, F3_XOR, 3, OPC_OP_IMM), chain ^ sx12(12'hF0F));
    chain_step(r_type(7'h20, 2, 3, F3_SR, 3), 64'($signed(chain) >>> b[5:0]));
    chain_step(i_type(12'h0C3, 3, F3_OR, 3, OPC_OP_IMM), chain | sx12(12'h0C3));
    chain_step(r_type(7'h00, 2, 3, F3_OR, 3), chain | b);
    chain_step(i_type(12'h007, 3, F3_SLL, 3, OPC_OP_IMM), chain << 7);
    chain_step(r_type(7'h00, 2, 3, F3_AND, 3), chain & b);
    chain_step(i_type(12'h003, 3, F3_SR, 3, OPC_OP_IMM), chain >> 3);
    chain_step(i_type(12'h8FF, 3, F3_AND, 3, OPC_OP_IMM), chain & sx12(12'h8FF));
    chain_step(i_type(12'h405, 3, F3_SR, 3, OPC_OP_IMM), 64'($signed(chain) >>> 5));   // SRAI
    chain_step(r_type(7'h00, 2, 3, F3_SLT, 3), 64'($signed(chain) < $signed(b)));
    chain_step(i_type(12'h123, 3, F3_SLT, 3, OPC_OP_IMM),
               64'($signed(chain) < $signed(sx12(12'h123))));
    close_program();
    wait_done("alu_chain");
    foreach (chain_want[i]) begin
        check_word($sformatf("alu_chain step %0d", i), 32'(16 + 8 * i), chain_want[i]);
    end
endtask

task automatic load_use_hazard();
    logic [63:0] x;
    logic [63:0] y;
    begin_program();
    x = dmem[0];
    y = dmem[1];
    emit(load_dword(5, 12'h008));
    emit(load_dword(6, 12'h000));
    emit(r_type(7'h00, 5, 6, F3_ADD, 7));   // rs1 waits on the load
    emit(store_dword(7, 12'h010));
    emit(load_dword(9, 12'h000));
    emit(r_type(7'h00, 9, 5, F3_ADD, 10));  // rs2 waits on the load
    emit(store_dword(10, 12'h018));
    close_program();
    wait_done("load_use_hazard");
    check_word("load_use_hazard rs1", 32'h10, x + y);
    check_word("load_use_hazard rs2", 32'h18, y + x);
endtask

// Two stores that a correct flush never lets through
task automatic poison_slots();
    emit(store_dword(1, POISON_ADDR[11:0]));
    emit(store_dword(1, POISON_ADDR[11:0]));
endtask

task automatic branch_and_jump();
    logic [31:0] jal_pc;
    int          hits;
    begin_program();
    emit(i_type(12'h007, 0, F3_ADD, 1, OPC_OP_IMM));
    emit(i_type(12'h007, 0, F3_ADD, 2, OPC_OP_IMM));
    emit(i_type(12'h009, 0, F3_ADD, 3, OPC_OP_IMM));
    emit(b_type(13'd12, 2, 1, F3_BEQ));     // Taken
    poison_slots();
    emit(i_type(12'h001, 0, F3_ADD, 4, OPC_OP_IMM));
    emit(store_dword(4, 12'h020));
    emit(b_type(13'd12, 3, 1, F3_BNE));     // Taken
    poison_slots();
    emit(b_type(13'd8, 3, 1, F3_BEQ));      // Not taken, x5 must be set
    emit(i_type(12'h002, 0, F3_ADD, 5, OPC_OP_IMM));
    emit(store_dword(5, 12'h028));
    emit(b_type(13'd8, 2, 1, F3_BNE));      // Not taken
    emit(i_type(12'h003, 0, F3_ADD, 6, OPC_OP_IMM));
    emit(store_dword(6, 12'h030));
    jal_pc = 32'(4 * prog_len);
    emit(j_type(21'd12, 7));
    poison_slots();
    emit(store_dword(7, 12'h038));
    close_program();
    wait_done("branch_and_jump");
    check_word("branch_and_jump beq taken", 32'h20, 64'd1);
    check_word("branch_and_jump beq not taken", 32'h28, 64'd2);
    check_word("branch_and_jump bne not taken", 32'h30, 64'd3);
    check_word("branch_and_jump jal link", 32'h38, 64'(jal_pc + 4));
    hits = 0;
    foreach (store_log[k]) begin
        if (store_log[k] == POISON_ADDR) begin
            hits++;
        end
    end
    check_value("branch_and_jump flushed stores", 64'd0, 64'(hits));
endtask

task automatic zero_register();
    begin_program();
    emit(i_type(12'h055, 0, F3_ADD, 0, OPC_OP_IMM));
    emit(i_type(12'h066, 0, F3_ADD, 0, OPC_OP_IMM));
    emit(store_dword(0, 12'h040));          // Right behind the writes
    close_program();
    wait_done("zero_register");
    check_word("zero_register", 32'h40, 64'd0);
    check_word("zero_register done word", DONE_ADDR, 64'd0);
endtask

// File: test/rv_core_tb.sv
// Testbench for the RV64 core with memory models, instruction encoders and result checks
`timescale 1ns/10ps
`include "rv_core_settings.svh"

module rv_core_tb
    import rv_isa_pkg::*, rv_pipe_pkg::*;
();

    localparam time         DRIVE_DLY    = 1;
    localparam int          DONE_TIMEOUT = 500;             // Cycles per wait
    localparam logic [31:0] DONE_ADDR    = 32'h0000_07F8;
    localparam logic [31:0] POISON_ADDR  = 32'h0000_0700;   // Target of flushed stores
    localparam int          IMEM_WORDS   = 256;
    localparam int          DMEM_WORDS   = 256;

    logic                clk = 1'b0;
    logic                rst = 1'b1;
    logic [`RV_PC_W-1:0] imem_addr;
    logic [`RV_ILEN-1:0] imem_rdata;
    dmem_req_t           dmem_req;
    logic [`RV_XLEN-1:0] dmem_rdata;

    logic [31:0] imem [IMEM_WORDS];
    logic [63:0] dmem [DMEM_WORDS] = '{default: '0};
    logic [31:0] store_log [$];
    logic        done_seen = 1'b0;
    logic [63:0] chain;                 // Running value of the ALU chain
    logic [63:0] chain_want [$];
    int          prog_len;
    integer      seed = 78;
    int          errors = 0;
    int          checks = 0;

    always #50 clk = ~clk;

    // Both memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.address[10:3]];

    // Data memory, refilled with random words during reset
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[8'(i)] = {$random(seed), $random(seed)};
            end
            store_log.delete();
            done_seen = 1'b0;
        end else if (dmem_req.wen) begin
            dmem[dmem_req.address[10:3]] = dmem_req.wdata;
            store_log.push_back(dmem_req.address);
            if (dmem_req.address == DONE_ADDR) begin
                done_seen = 1'b1;
            end
        end
    end

    rv_core i_dut (
        .clk          (clk),
        .rst          (rst),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input int rs1,
                                           input logic [2:0] f3, input int rd,
                                           input rv_opcode_e opc);
        return {imm, 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] load_dword(input int rd, input logic [11:0] off);
        return i_type(off, 0, F3_LD, rd, OPC_LOAD);      // Base is always x0
    endfunction

    function automatic logic [31:0] store_dword(input int rs2, input logic [11:0] off);
        return {off[11:5], 5'(rs2), 5'd0, F3_SD, off[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OPC_JAL};
    endfunction

    function automatic logic [63:0] sx12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[8'(prog_len)] = instr;
        prog_len++;
    endtask

    // Reset for two cycles and clear the program, data gets random words meanwhile
    task automatic begin_program();
        rst = 1'b1;
        prog_len = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[8'(i)] = '0;           // Illegal opcode, decodes to a bubble
        end
        repeat (2) @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Done store, then an idle loop
    task automatic close_program();
        emit(store_dword(0, DONE_ADDR[11:0]));
        emit(j_type(21'd0, 0));
        rst = 1'b0;
    endtask

    task automatic wait_done(input string name);
        int cyc;
        cyc = 0;
        while (!done_seen && cyc < DONE_TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DLY;
            cyc++;
        end
        if (!done_seen) begin
            $display("%s: timed out after %0d cycles, the program never finished", name, cyc);
            errors++;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] addr,
                              input logic [63:0] expected);
        check_value(name, expected, dmem[addr[10:3]]);
    endtask

    `include "rv_core_tests.svh"

    initial begin
        reset_state();
        alu_chain();
        load_use_hazard();
        branch_and_jump();
        zero_register();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: rv_core.f
+incdir+hw
+incdir+test
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_regfile.sv
hw/rv_fetch_decode.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core.sv
test/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and search the log for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rv_core_tb -Mdir obj_dir -f rv_core.f
./obj_dir/Vrv_core_tb > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
